// ==== slc3_stimulus.txt ====
# cmd args (hex): T name | L addr data | R | E led | K | X | M addr expected
# programs load at address 0 while halted, X resets and keeps the ram
T alu_ops
L 000 1227
L 001 143D
L 002 1642
L 003 5842
L 004 5AAE
L 005 9C7F
L 006 1EB0
L 007 7218
L 008 7419
L 009 761A
L 00A 781B
L 00B 7A1C
L 00C 7C1D
L 00D 7E1E
L 00E D0A1
R
E 0A1
X
M 018 0007
M 019 FFFD
M 01A 0004
M 01B 0005
M 01C 000C
M 01D FFF8
M 01E FFED
T ldr_str
L 000 122C
L 001 6454
L 002 667E
L 003 7458
L 004 7659
L 005 D0B2
L 020 BEEF
L 00A 1234
R
E 0B2
X
M 024 BEEF
M 025 1234
T branch
L 018 0000
L 019 0000
L 01A 0000
L 01B 0000
L 01C 0000
L 01D 0000
L 01E 0000
L 000 1A29
L 001 123F
L 002 0801
L 003 7A18
L 004 0601
L 005 7A19
L 006 5420
L 007 0401
L 008 7A1A
L 009 0A01
L 00A 7A1B
L 00B 1625
L 00C 0201
L 00D 7A1C
L 00E 0C01
L 00F 7A1D
L 010 0001
L 011 7A1E
L 012 D0C3
R
E 0C3
X
M 018 0000
M 019 0009
M 01A 0000
M 01B 0009
M 01C 0000
M 01D 0009
M 01E 0009
T jsr_jmp
L 018 0000
L 019 0000
L 01A 0000
L 000 1223
L 001 4803
L 002 7E18
L 003 D0D4
L 004 0000
L 005 7E19
L 006 1261
L 007 721A
L 008 C1C0
R
E 0D4
X
M 018 0002
M 019 0002
M 01A 0004
T pause
L 018 0000
L 000 D123
L 001 1226
L 002 7218
L 003 DABC
R
E 123
K
E ABC
X
M 018 0006

// ==== verilog.f ====
slc3_pkg.sv
slc3_mem_timer.sv
slc3_regfile.sv
slc3_datapath.sv
slc3_control.sv
slc3_ram.sv
slc3_top.sv
tb_slc3.sv

// ==== run_sim.sh ====
#!/bin/bash
# build and run the SLC-3 testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary -f verilog.f --top-module tb_slc3 -o tb_slc3_sim
./obj_dir/tb_slc3_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Test failures found" sim.log; then
	exit 1
fi
if ! grep -q "All tests passed!" sim.log; then
	exit 1
fi
exit 0

// ==== tb_slc3.sv ====
module tb_slc3;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int MEM_ADDR_W  = 10;
	localparam int RAM_LATENCY = 3;
	localparam int MAX_STEPS   = 64;                   // instructions per run segment
	localparam int INSTR_MAX   = 2 * RAM_LATENCY + 8;  // worst case is str plus fetch
	localparam int PAUSE_LIMIT = MAX_STEPS * INSTR_MAX; // cycles to wait for paused_o

	logic                        clk;
	logic                        reset;
	logic                        run_i;
	logic                        continue_i;
	logic                        dbg_we_i;
	logic [MEM_ADDR_W-1:0]       dbg_addr_i;
	logic [slc3_pkg::WORD_W-1:0] dbg_wdata_i;
	logic [slc3_pkg::WORD_W-1:0] dbg_rdata_o;
	logic [slc3_pkg::LED_W-1:0]  led_o;
	logic                        paused_o;
	logic                        halted_o;

	// parsed stimulus with one entry per command
	byte         cmd_q [$];
	logic [31:0] arg_a_q [$];
	logic [31:0] arg_b_q [$];
	string       name_q [$];

	int    errors;       // failing checks over the run
	int    test_errors;  // failing checks in the current test
	int    tests_run;
	int    tests_failed;
	string cur_test;
	logic  watch_armed;
	int    watch_cycles;

	slc3_top #(
		.MEM_ADDR_W  (MEM_ADDR_W),
		.RAM_LATENCY (RAM_LATENCY)
	) UUT (
		.clk         (clk),
		.reset       (reset),
		.run_i       (run_i),
		.continue_i  (continue_i),
		.dbg_we_i    (dbg_we_i),
		.dbg_addr_i  (dbg_addr_i),
		.dbg_wdata_i (dbg_wdata_i),
		.dbg_rdata_o (dbg_rdata_o),
		.led_o       (led_o),
		.paused_o    (paused_o),
		.halted_o    (halted_o)
	);

	always #2 clk = ~clk; // 4 ns period

	// -------------------------------------------------------------------
	// compare tasks
	// -------------------------------------------------------------------
	task automatic check_word(string sig, logic [slc3_pkg::WORD_W-1:0] got,
		logic [slc3_pkg::WORD_W-1:0] exp);
		if (got !== exp)
		begin
			$display("** Error: %s = %h, expected %h (test %s)", sig, got, exp, cur_test);
			errors++;
			test_errors++;
		end
	endtask

	task automatic check_led(string sig, logic [slc3_pkg::LED_W-1:0] got,
		logic [slc3_pkg::LED_W-1:0] exp);
		if (got !== exp)
		begin
			$display("** Error: %s = %h, expected %h (test %s)", sig, got, exp, cur_test);
			errors++;
			test_errors++;
		end
	endtask

	task automatic check_flag(string sig, logic got, logic exp);
		if (got !== exp)
		begin
			$display("** Error: %s = %h, expected %h (test %s)", sig, got, exp, cur_test);
			errors++;
			test_errors++;
		end
	endtask

	// -------------------------------------------------------------------
	// bus-level helpers
	// -------------------------------------------------------------------
	task automatic step; // drive point just after the rising edge
		@(posedge clk);
		#1;
	endtask

	task automatic apply_reset;
		step();
		reset = 1'b1;
		repeat (8) step();
		reset = 1'b0;
		@(negedge clk);
		check_flag("halted_o", halted_o, 1'b1);
		check_flag("paused_o", paused_o, 1'b0);
		check_led("led_o", led_o, '0);
	endtask

	task automatic debug_write(logic [MEM_ADDR_W-1:0] addr, logic [slc3_pkg::WORD_W-1:0] data);
		step();
		dbg_addr_i  = addr;
		dbg_wdata_i = data;
		dbg_we_i    = 1'b1;
		step();
		dbg_we_i = 1'b0;
	endtask

	task automatic debug_read_check(logic [MEM_ADDR_W-1:0] addr,
		logic [slc3_pkg::WORD_W-1:0] exp);
		step();
		dbg_addr_i = addr; // address held while the ram latency runs out
		repeat (RAM_LATENCY) @(posedge clk);
		@(negedge clk);
		check_word($sformatf("dbg_rdata_o[%h]", addr), dbg_rdata_o, exp);
	endtask

	task automatic wait_paused(logic level);
		int n;
		n = 0;
		@(negedge clk);
		while (paused_o !== level)
		begin
			n++;
			if (n > PAUSE_LIMIT)
			begin
				$display("paused_o did not go %0d within %0d cycles in test %s",
					level, PAUSE_LIMIT, cur_test);
				errors++;
				test_errors++;
				return;
			end
			@(negedge clk);
		end
	endtask

	task automatic run_program;
		step();
		run_i = 1'b1;
		step();
		run_i = 1'b0;
		wait_paused(1'b1);
		@(negedge clk); // led register loads in the first pause cycle
	endtask

	task automatic press_continue;
		step();
		continue_i = 1'b1;
		repeat (3) step();
		@(negedge clk);
		check_flag("paused_o", paused_o, 1'b1); // held until release
		step();
		continue_i = 1'b0;
		wait_paused(1'b0);
		wait_paused(1'b1);
		@(negedge clk);
	endtask

	task automatic finish_test;
		if (cur_test.len() > 0)
		begin
			tests_run++;
			if (test_errors != 0)
				tests_failed++;
			$display("test %-12s : %s, %0d failing checks", cur_test,
				(test_errors == 0) ? "ok" : "FAIL", test_errors);
		end
		test_errors = 0;
	endtask

	// -------------------------------------------------------------------
	// stimulus file parsing
	// -------------------------------------------------------------------
	function automatic bit is_space(byte c);
		return (c == 8'h20) || (c == 8'h09) || (c == 8'h0a) || (c == 8'h0d);
	endfunction

	function automatic string trim(string s);
		int b;
		int e;
		b = 0;
		e = s.len() - 1;
		while (b <= e && is_space(s.getc(b)))
			b++;
		while (e >= b && is_space(s.getc(e)))
			e--;
		if (b > e)
			return "";
		return s.substr(b, e);
	endfunction

	task automatic read_stimulus(output bit ok);
		int          fd;
		string       line;
		string       rest;
		byte         c;
		logic [31:0] a;
		logic [31:0] b;
		ok = 1'b0;
		fd = $fopen("slc3_stimulus.txt", "r");
		if (fd == 0)
		begin
			$display("could not open slc3_stimulus.txt");
			return;
		end
		while ($fgets(line, fd) != 0)
		begin
			line = trim(line);
			if (line.len() == 0 || line.getc(0) == "#")
				continue; // blank or comment
			c    = line.getc(0);
			rest = (line.len() > 1) ? trim(line.substr(1, line.len() - 1)) : "";
			a    = '0;
			b    = '0;
			if (c != "T")
				void'($sscanf(rest, "%h %h", a, b));
			cmd_q.push_back(c);
			arg_a_q.push_back(a);
			arg_b_q.push_back(b);
			name_q.push_back(rest);
		end
		$fclose(fd);
		ok = 1'b1;
	endtask

	// watchdog sized once the command count is known
	initial
	begin
		wait (watch_armed === 1'b1);
		repeat (watch_cycles) @(posedge clk);
		$display("watchdog expired after %0d cycles, simulation stopped", watch_cycles);
		$display("Test failures found");
		$finish;
	end

	initial
	begin
		bit ok;
		clk          = 1'b0;
		reset        = 1'b1;
		run_i        = 1'b0;
		continue_i   = 1'b0;
		dbg_we_i     = 1'b0;
		dbg_addr_i   = '0;
		dbg_wdata_i  = '0;
		errors       = 0;
		test_errors  = 0;
		tests_run    = 0;
		tests_failed = 0;
		cur_test     = "";
		watch_armed  = 1'b0;
		watch_cycles = 0;

		read_stimulus(ok);
		if (!ok)
		begin
			$display("Test failures found");
			$finish;
		end
		else
		begin
			watch_cycles = (cmd_q.size() + 4) * MAX_STEPS * INSTR_MAX;
			watch_armed  = 1'b1;
			apply_reset();
			foreach (cmd_q[i])
			begin
				case (cmd_q[i])
					"T":
					begin
						finish_test();
						cur_test = name_q[i];
					end
					"L": debug_write(arg_a_q[i][MEM_ADDR_W-1:0], arg_b_q[i][15:0]);
					"R": run_program();
					"E": check_led("led_o", led_o, arg_a_q[i][slc3_pkg::LED_W-1:0]);
					"K": press_continue();
					"X": apply_reset();
					"M": debug_read_check(arg_a_q[i][MEM_ADDR_W-1:0], arg_b_q[i][15:0]);
					default:
					begin
						$display("unknown stimulus command '%c'", cmd_q[i]);
						errors++;
					end
				endcase
			end
			finish_test();
			$display("%0d tests run, %0d tests failing, %0d failing checks",
				tests_run, tests_failed, errors);
			if (errors == 0)
				$display("All tests passed!");
			else
				$display("Test failures found");
			$finish;
		end
	end

endmodule

// ==== slc3_top.sv ====
module slc3_top #(
	parameter int MEM_ADDR_W  = 10,
	parameter int RAM_LATENCY = 3
) (
	input  logic                        clk,
	input  logic                        reset,
	input  logic                        run_i,
	input  logic                        continue_i,
	input  logic                        dbg_we_i,
	input  logic [MEM_ADDR_W-1:0]       dbg_addr_i,
	input  logic [slc3_pkg::WORD_W-1:0] dbg_wdata_i,
	output logic [slc3_pkg::WORD_W-1:0] dbg_rdata_o,
	output logic [slc3_pkg::LED_W-1:0]  led_o,
	output logic                        paused_o,
	output logic                        halted_o
);

	// control strobes
	logic ld_mar;
	logic ld_mdr;
	logic ld_ir;
	logic ld_pc;
	logic ld_reg;
	logic ld_cc;
	logic ld_ben;
	logic ld_led;
	logic dr_sel;
	logic sr1_sel;
	logic sr2_sel;
	logic addr1_sel;
	slc3_pkg::addr2_t   addr2_sel;
	slc3_pkg::pcmux_t   pcmux;
	slc3_pkg::aluk_t    aluk;
	slc3_pkg::bus_src_t bus_src;

	// memory side
	logic mem_ena;
	logic mem_we;
	logic mem_start;
	logic mem_done;
	logic [MEM_ADDR_W-1:0]       mar;
	logic [slc3_pkg::WORD_W-1:0] mdr;
	logic [slc3_pkg::WORD_W-1:0] mem_rdata;

	// back to control
	logic [slc3_pkg::WORD_W-1:0] ir;
	logic                        ben;

	slc3_control u_control (
		.clk         (clk),
		.reset       (reset),
		.ir_i        (ir),
		.ben_i       (ben),
		.run_i       (run_i),
		.continue_i  (continue_i),
		.mem_done_i  (mem_done),
		.ld_mar_o    (ld_mar),
		.ld_mdr_o    (ld_mdr),
		.ld_ir_o     (ld_ir),
		.ld_pc_o     (ld_pc),
		.ld_reg_o    (ld_reg),
		.ld_cc_o     (ld_cc),
		.ld_ben_o    (ld_ben),
		.ld_led_o    (ld_led),
		.dr_sel_o    (dr_sel),
		.sr1_sel_o   (sr1_sel),
		.sr2_sel_o   (sr2_sel),
		.addr1_sel_o (addr1_sel),
		.addr2_sel_o (addr2_sel),
		.pcmux_o     (pcmux),
		.aluk_o      (aluk),
		.bus_src_o   (bus_src),
		.mem_ena_o   (mem_ena),
		.mem_we_o    (mem_we),
		.mem_start_o (mem_start),
		.paused_o    (paused_o),
		.halted_o    (halted_o)
	);

	slc3_mem_timer #(
		.RAM_LATENCY (RAM_LATENCY)
	) u_mem_timer (
		.clk     (clk),
		.reset   (reset),
		.start_i (mem_start),
		.done_o  (mem_done)
	);

	slc3_datapath #(
		.MEM_ADDR_W (MEM_ADDR_W)
	) u_datapath (
		.clk         (clk),
		.reset       (reset),
		.ld_mar_i    (ld_mar),
		.ld_mdr_i    (ld_mdr),
		.ld_ir_i     (ld_ir),
		.ld_pc_i     (ld_pc),
		.ld_reg_i    (ld_reg),
		.ld_cc_i     (ld_cc),
		.ld_ben_i    (ld_ben),
		.ld_led_i    (ld_led),
		.dr_sel_i    (dr_sel),
		.sr1_sel_i   (sr1_sel),
		.sr2_sel_i   (sr2_sel),
		.addr1_sel_i (addr1_sel),
		.addr2_sel_i (addr2_sel),
		.pcmux_i     (pcmux),
		.aluk_i      (aluk),
		.bus_src_i   (bus_src),
		.mem_rdata_i (mem_rdata),
		.ir_o        (ir),
		.ben_o       (ben),
		.mar_o       (mar),
		.mdr_o       (mdr),
		.led_o       (led_o)
	);

	slc3_ram #(
		.MEM_ADDR_W  (MEM_ADDR_W),
		.RAM_LATENCY (RAM_LATENCY)
	) u_ram (
		.clk         (clk),
		.mem_ena_i   (mem_ena),
		.mem_we_i    (mem_we),
		.addr_i      (mar),
		.wdata_i     (mdr),
		.rdata_o     (mem_rdata),
		.dbg_en_i    (halted_o), // debug access only while halted
		.dbg_we_i    (dbg_we_i),
		.dbg_addr_i  (dbg_addr_i),
		.dbg_wdata_i (dbg_wdata_i),
		.dbg_rdata_o (dbg_rdata_o)
	);

endmodule

// ==== slc3_ram.sv ====
module slc3_ram #(
	parameter int MEM_ADDR_W  = 10,
	parameter int RAM_LATENCY = 3   // at least 2, array read plus outputs
) (
	input  logic                        clk,
	input  logic                        mem_ena_i,
	input  logic                        mem_we_i,
	input  logic [MEM_ADDR_W-1:0]       addr_i,
	input  logic [slc3_pkg::WORD_W-1:0] wdata_i,
	output logic [slc3_pkg::WORD_W-1:0] rdata_o,
	input  logic                        dbg_en_i,  // processor halted
	input  logic                        dbg_we_i,
	input  logic [MEM_ADDR_W-1:0]       dbg_addr_i,
	input  logic [slc3_pkg::WORD_W-1:0] dbg_wdata_i,
	output logic [slc3_pkg::WORD_W-1:0] dbg_rdata_o
);

	localparam int STAGES = RAM_LATENCY - 1; // array register + output regs

	logic [slc3_pkg::WORD_W-1:0] mem [2 ** MEM_ADDR_W];
	logic [slc3_pkg::WORD_W-1:0] pipe [STAGES];
	logic [MEM_ADDR_W-1:0]       addr;
	logic [slc3_pkg::WORD_W-1:0] wdata;
	logic                        ena;
	logic                        we;

	// debug port owns the array while halted
	assign addr  = dbg_en_i ? dbg_addr_i : addr_i;
	assign wdata = dbg_en_i ? dbg_wdata_i : wdata_i;
	assign ena   = dbg_en_i || mem_ena_i;
	assign we    = dbg_en_i ? dbg_we_i : (mem_ena_i && mem_we_i);

	always_ff @(posedge clk)
	begin
		if (we)
			mem[addr] <= wdata;
		if (ena)
			pipe[0] <= mem[addr]; // read before write
		for (int i = 1; i < STAGES; i++)
			pipe[i] <= pipe[i-1]; // output register chain
	end

	assign rdata_o     = pipe[STAGES-1];
	assign dbg_rdata_o = pipe[STAGES-1]; // same path, same latency

endmodule

// ==== slc3_control.sv ====
module slc3_control (
	input  logic                        clk,
	input  logic                        reset,
	input  logic [slc3_pkg::WORD_W-1:0] ir_i,        // instruction register
	input  logic                        ben_i,       // registered branch enable
	input  logic                        run_i,
	input  logic                        continue_i,
	input  logic                        mem_done_i,  // last ram wait cycle
	output logic                        ld_mar_o,
	output logic                        ld_mdr_o,
	output logic                        ld_ir_o,
	output logic                        ld_pc_o,
	output logic                        ld_reg_o,
	output logic                        ld_cc_o,
	output logic                        ld_ben_o,
	output logic                        ld_led_o,
	output logic                        dr_sel_o,    // 1 = r7
	output logic                        sr1_sel_o,   // 1 = ir[8:6], 0 = ir[11:9]
	output logic                        sr2_sel_o,   // 1 = imm5
	output logic                        addr1_sel_o, // 1 = sr1, 0 = pc
	output slc3_pkg::addr2_t            addr2_sel_o,
	output slc3_pkg::pcmux_t            pcmux_o,
	output slc3_pkg::aluk_t             aluk_o,
	output slc3_pkg::bus_src_t          bus_src_o,
	output logic                        mem_ena_o,
	output logic                        mem_we_o,
	output logic                        mem_start_o, // arms the wait timer
	output logic                        paused_o,
	output logic                        halted_o
);

	typedef enum logic [5:0] {
		halted,
		s_fetch,     // mar <- pc, pc <- pc + 1
		s_fetch_wait,
		s_load_ir,
		s_decode,
		s_add,
		s_addi,
		s_and,
		s_andi,
		s_not,
		s_ldr_addr,
		s_ldr_wait,
		s_ldr_load,
		s_str_addr,
		s_str_mdr,
		s_str_write,
		s_jsr_link,
		s_jsr_jump,
		s_jmp,
		s_br_test,
		s_br_take,
		pause_1,
		pause_2
	} state_t;

	state_t state;
	state_t state_nxt;
	slc3_pkg::opcode_t opcode;

	assign opcode = slc3_pkg::opcode_t'(ir_i[15:12]);

	always_ff @(posedge clk)
	begin
		if (reset)
			state <= halted;
		else
			state <= state_nxt;
	end

	// -------------------------------------------------------------------
	// control outputs, defaults first so each state lists only changes
	// -------------------------------------------------------------------
	always_comb
	begin
		ld_mar_o    = 1'b0;
		ld_mdr_o    = 1'b0;
		ld_ir_o     = 1'b0;
		ld_pc_o     = 1'b0;
		ld_reg_o    = 1'b0;
		ld_cc_o     = 1'b0;
		ld_ben_o    = 1'b0;
		ld_led_o    = 1'b0;
		dr_sel_o    = 1'b0;
		sr1_sel_o   = 1'b1; // alu ops and bases read ir[8:6]
		sr2_sel_o   = 1'b0;
		addr1_sel_o = 1'b0;
		addr2_sel_o = slc3_pkg::ADDR2_ZERO;
		pcmux_o     = slc3_pkg::PC_INC;
		aluk_o      = slc3_pkg::ALU_ADD;
		bus_src_o   = slc3_pkg::BUS_PC;
		mem_ena_o   = 1'b0;
		mem_we_o    = 1'b0;
		mem_start_o = 1'b0;
		paused_o    = 1'b0;
		halted_o    = 1'b0;

		case (state)
			halted: halted_o = 1'b1;
			s_fetch:
			begin
				ld_mar_o    = 1'b1; // bus carries pc
				ld_pc_o     = 1'b1;
				mem_start_o = 1'b1;
			end
			s_fetch_wait, s_ldr_wait:
			begin
				mem_ena_o = 1'b1;
				ld_mdr_o  = 1'b1; // final cycle holds valid data
			end
			s_load_ir:
			begin
				ld_ir_o   = 1'b1;
				bus_src_o = slc3_pkg::BUS_MDR;
			end
			s_decode: ld_ben_o = 1'b1;
			s_add, s_addi, s_and, s_andi, s_not:
			begin
				ld_reg_o  = 1'b1;
				ld_cc_o   = 1'b1;
				bus_src_o = slc3_pkg::BUS_ALU;
				sr2_sel_o = (state == s_addi) || (state == s_andi);
				if (state == s_and || state == s_andi)
					aluk_o = slc3_pkg::ALU_AND;
				else if (state == s_not)
					aluk_o = slc3_pkg::ALU_NOT;
			end
			s_ldr_addr, s_str_addr:
			begin
				ld_mar_o    = 1'b1;
				addr1_sel_o = 1'b1; // base register
				addr2_sel_o = slc3_pkg::ADDR2_OFF6;
				bus_src_o   = slc3_pkg::BUS_MARMUX;
				mem_start_o = (state == s_ldr_addr);
			end
			s_ldr_load:
			begin
				ld_reg_o  = 1'b1;
				ld_cc_o   = 1'b1;
				bus_src_o = slc3_pkg::BUS_MDR;
			end
			s_str_mdr:
			begin
				ld_mdr_o    = 1'b1;
				sr1_sel_o   = 1'b0; // source register sits in ir[11:9]
				aluk_o      = slc3_pkg::ALU_PASS;
				bus_src_o   = slc3_pkg::BUS_ALU;
				mem_start_o = 1'b1;
			end
			s_str_write:
			begin
				mem_ena_o = 1'b1;
				mem_we_o  = 1'b1;
			end
			s_jsr_link:
			begin
				ld_reg_o = 1'b1; // r7 <- incremented pc
				dr_sel_o = 1'b1;
			end
			s_jsr_jump:
			begin
				ld_pc_o     = 1'b1;
				pcmux_o     = slc3_pkg::PC_ADDER;
				addr2_sel_o = slc3_pkg::ADDR2_OFF11;
			end
			s_jmp:
			begin
				ld_pc_o   = 1'b1;
				pcmux_o   = slc3_pkg::PC_BUS;
				aluk_o    = slc3_pkg::ALU_PASS;
				bus_src_o = slc3_pkg::BUS_ALU;
			end
			s_br_take:
			begin
				ld_pc_o     = 1'b1;
				pcmux_o     = slc3_pkg::PC_ADDER;
				addr2_sel_o = slc3_pkg::ADDR2_OFF9;
			end
			pause_1:
			begin
				ld_led_o = 1'b1;
				paused_o = 1'b1;
			end
			pause_2: paused_o = 1'b1;
			default: ;
		endcase
	end

	// -------------------------------------------------------------------
	// next state
	// -------------------------------------------------------------------
	always_comb
	begin
		state_nxt = state; // waits hold by default
		case (state)
			halted: if (run_i) state_nxt = s_fetch;
			s_fetch: state_nxt = s_fetch_wait;
			s_fetch_wait: if (mem_done_i) state_nxt = s_load_ir;
			s_load_ir: state_nxt = s_decode;
			s_decode:
			begin
				case (opcode)
					slc3_pkg::OP_ADD: state_nxt = ir_i[5] ? s_addi : s_add;
					slc3_pkg::OP_AND: state_nxt = ir_i[5] ? s_andi : s_and;
					slc3_pkg::OP_NOT: state_nxt = s_not;
					slc3_pkg::OP_LDR: state_nxt = s_ldr_addr;
					slc3_pkg::OP_STR: state_nxt = s_str_addr;
					slc3_pkg::OP_JSR: state_nxt = s_jsr_link;
					slc3_pkg::OP_JMP: state_nxt = s_jmp;
					slc3_pkg::OP_BR:  state_nxt = s_br_test;
					slc3_pkg::OP_PSE: state_nxt = pause_1;
					default:          state_nxt = s_fetch; // unsupported, skip
				endcase
			end
			s_ldr_addr: state_nxt = s_ldr_wait;
			s_ldr_wait: if (mem_done_i) state_nxt = s_ldr_load;
			s_str_addr: state_nxt = s_str_mdr;
			s_str_mdr: state_nxt = s_str_write;
			s_str_write: if (mem_done_i) state_nxt = s_fetch;
			s_jsr_link: state_nxt = s_jsr_jump;
			s_br_test: state_nxt = ben_i ? s_br_take : s_fetch;
			pause_1: if (continue_i) state_nxt = pause_2;
			pause_2: if (!continue_i) state_nxt = s_fetch; // wait for release
			default: state_nxt = s_fetch; // single-cycle executes
		endcase
	end

endmodule

// ==== slc3_datapath.sv ====
module slc3_datapath #(
	parameter int MEM_ADDR_W = 10
) (
	input  logic                        clk,
	input  logic                        reset,
	input  logic                        ld_mar_i,
	input  logic                        ld_mdr_i,
	input  logic                        ld_ir_i,
	input  logic                        ld_pc_i,
	input  logic                        ld_reg_i,
	input  logic                        ld_cc_i,
	input  logic                        ld_ben_i,
	input  logic                        ld_led_i,
	input  logic                        dr_sel_i,
	input  logic                        sr1_sel_i,
	input  logic                        sr2_sel_i,
	input  logic                        addr1_sel_i,
	input  slc3_pkg::addr2_t            addr2_sel_i,
	input  slc3_pkg::pcmux_t            pcmux_i,
	input  slc3_pkg::aluk_t             aluk_i,
	input  slc3_pkg::bus_src_t          bus_src_i,
	input  logic [slc3_pkg::WORD_W-1:0] mem_rdata_i,
	output logic [slc3_pkg::WORD_W-1:0] ir_o,
	output logic                        ben_o,
	output logic [MEM_ADDR_W-1:0]       mar_o,
	output logic [slc3_pkg::WORD_W-1:0] mdr_o,
	output logic [slc3_pkg::LED_W-1:0]  led_o
);

	localparam int W = slc3_pkg::WORD_W;

	logic [W-1:0] pc;
	logic [W-1:0] pc_nxt;
	logic [W-1:0] bus;
	logic [W-1:0] sr1_data;
	logic [W-1:0] sr2_data;
	logic [W-1:0] sr2_operand;   // register or imm5
	logic [W-1:0] alu_out;
	logic [W-1:0] addr1;
	logic [W-1:0] addr2;
	logic [W-1:0] addr_sum;      // marmux value
	logic [slc3_pkg::REG_SEL_W-1:0] dr;
	logic [slc3_pkg::REG_SEL_W-1:0] sr1;
	logic n_flag;
	logic z_flag;
	logic p_flag;

	// register selection
	assign dr  = dr_sel_i ? 3'b111 : ir_o[11:9];
	assign sr1 = sr1_sel_i ? ir_o[8:6] : ir_o[11:9];

	slc3_regfile u_regfile (
		.clk        (clk),
		.reset      (reset),
		.ld_i       (ld_reg_i),
		.dr_i       (dr),
		.sr1_i      (sr1),
		.sr2_i      (ir_o[2:0]),
		.bus_i      (bus),
		.sr1_data_o (sr1_data),
		.sr2_data_o (sr2_data)
	);

	// -------------------------------------------------------------------
	// alu, address adder and bus
	// -------------------------------------------------------------------
	assign sr2_operand = sr2_sel_i ? {{(W-5){ir_o[4]}}, ir_o[4:0]} : sr2_data;

	always_comb
	begin
		case (aluk_i)
			slc3_pkg::ALU_ADD: alu_out = sr1_data + sr2_operand;
			slc3_pkg::ALU_AND: alu_out = sr1_data & sr2_operand;
			slc3_pkg::ALU_NOT: alu_out = ~sr1_data;
			default:           alu_out = sr1_data; // pass
		endcase
	end

	assign addr1 = addr1_sel_i ? sr1_data : pc;

	always_comb
	begin
		case (addr2_sel_i)
			slc3_pkg::ADDR2_OFF6:  addr2 = {{(W-6){ir_o[5]}}, ir_o[5:0]};
			slc3_pkg::ADDR2_OFF9:  addr2 = {{(W-9){ir_o[8]}}, ir_o[8:0]};
			slc3_pkg::ADDR2_OFF11: addr2 = {{(W-11){ir_o[10]}}, ir_o[10:0]};
			default:               addr2 = '0;
		endcase
	end

	assign addr_sum = addr1 + addr2;

	always_comb
	begin
		case (bus_src_i)
			slc3_pkg::BUS_MDR: bus = mdr_o;
			slc3_pkg::BUS_ALU: bus = alu_out;
			slc3_pkg::BUS_MARMUX: bus = addr_sum;
			default: bus = pc;
		endcase
	end

	always_comb
	begin
		case (pcmux_i)
			slc3_pkg::PC_BUS:   pc_nxt = bus;
			slc3_pkg::PC_ADDER: pc_nxt = addr_sum; // branch or jsr target
			default:            pc_nxt = pc + W'(1);
		endcase
	end

	// -------------------------------------------------------------------
	// architectural registers
	// -------------------------------------------------------------------
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			pc     <= '0;
			ir_o   <= '0;
			mar_o  <= '0;
			mdr_o  <= '0;
			led_o  <= '0;
			n_flag <= 1'b0;
			z_flag <= 1'b0;
			p_flag <= 1'b0;
			ben_o  <= 1'b0;
		end
		else
		begin
			if (ld_pc_i)
				pc <= pc_nxt;
			if (ld_ir_i)
				ir_o <= bus;
			if (ld_mar_i)
				mar_o <= bus[MEM_ADDR_W-1:0]; // ram is smaller than 64k
			if (ld_mdr_i) // str phase drives the alu onto the bus
				mdr_o <= (bus_src_i == slc3_pkg::BUS_ALU) ? bus : mem_rdata_i;
			if (ld_led_i)
				led_o <= ir_o[slc3_pkg::LED_W-1:0];
			if (ld_cc_i)
			begin
				n_flag <= bus[W-1];
				z_flag <= (bus == '0);
				p_flag <= !bus[W-1] && (bus != '0);
			end
			if (ld_ben_i)
				ben_o <= |(ir_o[11:9] & {n_flag, z_flag, p_flag}); // nzp match
		end
	end

endmodule

// ==== slc3_regfile.sv ====
module slc3_regfile (
	input  logic                           clk,
	input  logic                           reset,
	input  logic                           ld_i,
	input  logic [slc3_pkg::REG_SEL_W-1:0] dr_i,
	input  logic [slc3_pkg::REG_SEL_W-1:0] sr1_i,
	input  logic [slc3_pkg::REG_SEL_W-1:0] sr2_i,
	input  logic [slc3_pkg::WORD_W-1:0]    bus_i,
	output logic [slc3_pkg::WORD_W-1:0]    sr1_data_o,
	output logic [slc3_pkg::WORD_W-1:0]    sr2_data_o
);

	localparam int NUM_REGS = 2 ** slc3_pkg::REG_SEL_W;

	logic [slc3_pkg::WORD_W-1:0] regs [NUM_REGS];

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			for (int i = 0; i < NUM_REGS; i++)
				regs[i] <= '0;
		end
		else if (ld_i)
			regs[dr_i] <= bus_i; // write from bus
	end

	// two independent async read ports
	assign sr1_data_o = regs[sr1_i];
	assign sr2_data_o = regs[sr2_i];

endmodule

// ==== slc3_mem_timer.sv ====
module slc3_mem_timer #(
	parameter int RAM_LATENCY = 3
) (
	input  logic clk,
	input  logic reset,
	input  logic start_i, // one pulse per access
	output logic done_o   // last wait cycle
);

	localparam int CNT_W = $clog2(RAM_LATENCY + 1);

	logic [CNT_W-1:0] count; // zero when idle

	always_ff @(posedge clk)
	begin
		if (reset)
			count <= '0;
		else if (start_i)
			count <= CNT_W'(RAM_LATENCY);
		else if (count != '0)
			count <= count - CNT_W'(1);
	end

	assign done_o = (count == CNT_W'(1));

endmodule

// ==== slc3_pkg.sv ====
package slc3_pkg;

	// -------------------------------------------------------------------
	// machine widths
	// -------------------------------------------------------------------
	localparam int WORD_W    = 16; // data and instruction word
	localparam int REG_SEL_W = 3;  // eight general registers
	localparam int LED_W     = 12; // pause display, ir[11:0]

	// -------------------------------------------------------------------
	// instruction field ir[15:12]
	// -------------------------------------------------------------------
	typedef enum logic [3:0] {
		OP_BR  = 4'b0000,
		OP_ADD = 4'b0001,
		OP_JSR = 4'b0100,
		OP_AND = 4'b0101,
		OP_LDR = 4'b0110,
		OP_STR = 4'b0111,
		OP_NOT = 4'b1001,
		OP_JMP = 4'b1100,
		OP_PSE = 4'b1101  // pause, shows ir[11:0] on leds
	} opcode_t;

	// alu operation, pass forwards sr1 untouched
	typedef enum logic [1:0] {
		ALU_ADD  = 2'b00,
		ALU_AND  = 2'b01,
		ALU_NOT  = 2'b11,
		ALU_PASS = 2'b10
	} aluk_t;

	// single driver of the internal bus
	typedef enum logic [1:0] {
		BUS_PC     = 2'b00,
		BUS_MDR    = 2'b01,
		BUS_ALU    = 2'b10,
		BUS_MARMUX = 2'b11 // address adder result
	} bus_src_t;

	// pc source
	typedef enum logic [1:0] {
		PC_INC   = 2'b00,
		PC_BUS   = 2'b01,
		PC_ADDER = 2'b10
	} pcmux_t;

	// second address adder input, sign-extended ir offsets
	typedef enum logic [1:0] {
		ADDR2_ZERO  = 2'b00,
		ADDR2_OFF6  = 2'b01,
		ADDR2_OFF9  = 2'b10,
		ADDR2_OFF11 = 2'b11
	} addr2_t;

endpackage
